// File: source/sma_sample_pkg.sv
package sma_sample_pkg;

	// sample data width
	localparam int sample_w = 32;

	// one input sample of the stream
	typedef struct packed {
		logic                       valid;
		logic signed [sample_w-1:0] data;
	} sample_t;

	// one average result
	typedef struct packed {
		logic                       valid;
		logic signed [sample_w-1:0] data;
	} avg_t;

endpackage

// File: source/sma_regs_pkg.sv
package sma_regs_pkg;

	// register offsets
	localparam logic [7:0] addr_ctrl   = 8'h00;
	localparam logic [7:0] addr_status = 8'h04;
	localparam logic [7:0] addr_avg    = 8'h08;

	// CTRL as control fields
	typedef struct packed {
		logic        enable;
		logic [26:0] reserved;
		logic [3:0]  window_log2;
	} ctrl_fields_t;

	// CTRL seen as raw APB word or as fields
	typedef union packed {
		logic [31:0]  raw;
		ctrl_fields_t fields;
	} ctrl_word_u;

	// STATUS register layout
	typedef struct packed {
		logic        filled;
		logic [15:0] fill_count;
		logic [14:0] reserved;
	} status_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic        pslverr;
		logic [31:0] prdata;
	} apb_rsp_t;

endpackage

// File: source/sma_apb_regs.sv
module sma_apb_regs #(
	parameter int MAX_WINDOW_LOG2 = 15
) (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  sma_regs_pkg::apb_req_t i_apb,
	output sma_regs_pkg::apb_rsp_t o_apb,
	input  sma_sample_pkg::avg_t   i_avg,
	input  sma_regs_pkg::status_t  i_status,
	output logic [3:0]             o_window_log2,
	output logic                   o_enable,
	output logic                   o_restart
);
	import sma_regs_pkg::*;

	ctrl_word_u  ctrl_q;
	ctrl_word_u  wr_ctrl;
	logic [31:0] avg_q;
	logic        restart_q;
	logic        access;
	logic        hit_ctrl;
	logic        hit_status;
	logic        hit_avg;
	logic        bad_window;
	logic        slverr;
	logic        ctrl_wr_ok;
	logic [31:0] rdata;

	// access phase and address decode
	assign access     = i_apb.psel && i_apb.penable;
	assign hit_ctrl   = (i_apb.paddr == addr_ctrl);
	assign hit_status = (i_apb.paddr == addr_status);
	assign hit_avg    = (i_apb.paddr == addr_avg);

	// incoming word decoded as CTRL fields for the range check
	assign wr_ctrl.raw = i_apb.pwdata;
	assign bad_window  = int'(wr_ctrl.fields.window_log2) > MAX_WINDOW_LOG2;

	assign slverr = access && (!(hit_ctrl || hit_status || hit_avg) ||
		(i_apb.pwrite && (hit_status || hit_avg)) ||
		(i_apb.pwrite && hit_ctrl && bad_window));

	assign ctrl_wr_ok = access && i_apb.pwrite && hit_ctrl && !bad_window;

	always_comb begin
		rdata = '0;
		if (access && !i_apb.pwrite) begin
			if (hit_ctrl)
				rdata = ctrl_q.raw;
			else if (hit_status)
				rdata = i_status;
			else if (hit_avg)
				rdata = avg_q;
		end
	end

	// zero wait states
	assign o_apb = '{pready: 1'b1, pslverr: slverr, prdata: rdata};

	// CTRL keeps only the defined fields, reserved bits read zero
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ctrl_q.raw <= '0;
			restart_q  <= 1'b0;
		end else begin
			restart_q <= ctrl_wr_ok &&
				(wr_ctrl.fields.window_log2 != ctrl_q.fields.window_log2);
			if (ctrl_wr_ok) begin
				ctrl_q.fields.enable      <= wr_ctrl.fields.enable;
				ctrl_q.fields.window_log2 <= wr_ctrl.fields.window_log2;
			end
		end
	end

	// last valid average
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			avg_q <= '0;
		else if (i_avg.valid)
			avg_q <= i_avg.data;
	end

	assign o_window_log2 = ctrl_q.fields.window_log2;
	assign o_enable      = ctrl_q.fields.enable;
	assign o_restart     = restart_q;

	// APB access phases are at least two cycles apart
	a_restart_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_restart |=> !o_restart);

endmodule

// File: source/sma_sample_ram.sv
module sma_sample_ram #(
	parameter int MAX_WINDOW_LOG2 = 15
) (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_clear,
	input  logic [3:0]                     i_window_log2,
	input  logic                           i_wr_en,
	input  logic signed [31:0]             i_wr_data,
	output logic signed [31:0]             o_old_data,
	output logic [MAX_WINDOW_LOG2:0]       o_fill_count
);
	localparam int DEPTH  = 2 ** MAX_WINDOW_LOG2;
	localparam int PTR_W  = MAX_WINDOW_LOG2;
	localparam int FILL_W = MAX_WINDOW_LOG2 + 1;

	logic signed [31:0] mem [DEPTH];
	logic [DEPTH-1:0]   slot_valid;
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   wr_slot;
	logic [FILL_W-1:0]  win_len;
	logic [FILL_W-1:0]  fill_q;

	assign win_len = FILL_W'(1) << i_window_log2;

	// restart writes land in slot 0
	assign wr_slot = i_clear ? '0 : wr_ptr;

	// departing sample, zero for slots not written since restart
	assign o_old_data = slot_valid[wr_ptr] ? mem[wr_ptr] : '0;

	always_ff @(posedge i_clk) begin
		if (i_wr_en)
			mem[wr_slot] <= i_wr_data;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			slot_valid <= '0;
			wr_ptr     <= '0;
			fill_q     <= '0;
		end else if (i_clear) begin
			slot_valid <= '0;
			if (i_wr_en)
				slot_valid[0] <= 1'b1;
			wr_ptr <= (i_wr_en && win_len != FILL_W'(1)) ? PTR_W'(1) : '0;
			fill_q <= i_wr_en ? FILL_W'(1) : '0;
		end else if (i_wr_en) begin
			slot_valid[wr_ptr] <= 1'b1;
			// wrap at the current window length
			if (FILL_W'(wr_ptr) == win_len - FILL_W'(1))
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
			if (fill_q < win_len)
				fill_q <= fill_q + 1'b1;
		end
	end

	assign o_fill_count = fill_q;

	// pointer may sit past a shrunk window only until the restart clears it
	a_ptr_in_window: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_clear |-> (FILL_W'(wr_ptr) < win_len));

endmodule

// File: source/sma_accumulator.sv
module sma_accumulator #(
	parameter int MAX_WINDOW_LOG2 = 15
) (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  sma_sample_pkg::sample_t   i_sample,
	input  logic [3:0]                i_window_log2,
	input  logic                      i_enable,
	input  logic                      i_restart,
	input  logic signed [31:0]        i_old_data,
	input  logic [MAX_WINDOW_LOG2:0]  i_fill_count,
	output logic                      o_wr_en,
	output logic signed [31:0]        o_wr_data,
	output logic                      o_clear,
	output sma_sample_pkg::avg_t      o_avg,
	output sma_regs_pkg::status_t     o_status
);
	import sma_sample_pkg::*;
	import sma_regs_pkg::*;

	localparam int SUM_W  = sample_w + MAX_WINDOW_LOG2;
	localparam int FILL_W = MAX_WINDOW_LOG2 + 1;

	logic                       accept;
	logic signed [SUM_W-1:0]    sum_q;
	logic signed [SUM_W-1:0]    sum_base;
	logic signed [SUM_W-1:0]    new_ext;
	logic signed [SUM_W-1:0]    old_ext;
	logic signed [SUM_W-1:0]    sum_next;
	logic signed [SUM_W-1:0]    sum_shift;
	logic signed [sample_w-1:0] avg_trunc;
	logic                       avg_valid_q;
	logic signed [sample_w-1:0] avg_data_q;
	logic [FILL_W-1:0]          win_len;
	logic                       filled;

	// a sample only counts while enabled
	assign accept = i_sample.valid && i_enable;

	// on restart the window starts empty, so old sum and departing slot are zero
	assign sum_base = i_restart ? '0 : sum_q;
	assign new_ext  = SUM_W'(i_sample.data);
	assign old_ext  = i_restart ? '0 : SUM_W'(i_old_data);
	assign sum_next = sum_base + new_ext - old_ext;

	// arithmetic shift gives truncated mean
	assign sum_shift = sum_next >>> i_window_log2;
	assign avg_trunc = sample_w'(sum_shift);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sum_q       <= '0;
			avg_valid_q <= 1'b0;
		end else begin
			avg_valid_q <= accept;
			if (accept)
				sum_q <= sum_next;
			else if (i_restart)
				sum_q <= '0;
		end
	end

	// result data
	always_ff @(posedge i_clk) begin
		if (accept)
			avg_data_q <= avg_trunc;
	end

	assign o_avg = '{valid: avg_valid_q, data: avg_data_q};

	// sample memory side
	assign o_wr_en   = accept;
	assign o_wr_data = i_sample.data;
	assign o_clear   = i_restart;

	// status from the memory fill count
	assign win_len = FILL_W'(1) << i_window_log2;
	assign filled  = (i_fill_count == win_len);

	assign o_status = '{
		filled:     filled,
		fill_count: 16'(i_fill_count),
		reserved:   '0
	};

	// mean of in-range samples always fits the sample width
	a_avg_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		accept |-> (sum_shift == SUM_W'(avg_trunc)));

endmodule

// File: source/sma_filter_top.sv
module sma_filter_top #(
	parameter int MAX_WINDOW_LOG2 = 15
) (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  sma_regs_pkg::apb_req_t  i_apb,
	output sma_regs_pkg::apb_rsp_t  o_apb,
	input  sma_sample_pkg::sample_t i_sample,
	output sma_sample_pkg::avg_t    o_avg
);
	import sma_sample_pkg::*;
	import sma_regs_pkg::*;

	logic [3:0]                 window_log2;
	logic                       enable;
	logic                       restart;
	logic                       wr_en;
	logic signed [sample_w-1:0] wr_data;
	logic                       clear;
	logic signed [sample_w-1:0] old_data;
	logic [MAX_WINDOW_LOG2:0]   fill_count;
	status_t                    status;

	sma_apb_regs #(.MAX_WINDOW_LOG2(MAX_WINDOW_LOG2)) u_sma_apb_regs (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_apb         (i_apb),
		.o_apb         (o_apb),
		.i_avg         (o_avg),
		.i_status      (status),
		.o_window_log2 (window_log2),
		.o_enable      (enable),
		.o_restart     (restart)
	);

	sma_accumulator #(.MAX_WINDOW_LOG2(MAX_WINDOW_LOG2)) u_sma_accumulator (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_sample      (i_sample),
		.i_window_log2 (window_log2),
		.i_enable      (enable),
		.i_restart     (restart),
		.i_old_data    (old_data),
		.i_fill_count  (fill_count),
		.o_wr_en       (wr_en),
		.o_wr_data     (wr_data),
		.o_clear       (clear),
		.o_avg         (o_avg),
		.o_status      (status)
	);

	sma_sample_ram #(.MAX_WINDOW_LOG2(MAX_WINDOW_LOG2)) u_sma_sample_ram (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_clear       (clear),
		.i_window_log2 (window_log2),
		.i_wr_en       (wr_en),
		.i_wr_data     (wr_data),
		.o_old_data    (old_data),
		.o_fill_count  (fill_count)
	);

endmodule

// File: tb/tb_sma_filter_top.sv
module tb_sma_filter_top;
	timeunit 1ns;
	timeprecision 100ps;
	import sma_sample_pkg::*;
	import sma_regs_pkg::*;

	localparam int MAX_WLOG2 = 6;

	logic               i_clk = 1'b0;
	logic               i_rst_n;
	apb_req_t           i_apb;
	apb_rsp_t           o_apb;
	sample_t            i_sample;
	avg_t               o_avg;
	integer             seed;
	int                 cycle, err_count, test_errs, test_fails;
	logic [3:0]         cur_wlog2;
	logic               cur_en;
	logic signed [31:0] hist[$];
	avg_t               exp_avg[$];
	int                 exp_due[$];
	avg_t               last_avg;
	apb_rsp_t           rsp;

	sma_filter_top #(.MAX_WINDOW_LOG2(MAX_WLOG2)) u_sma_filter_top (.*);

	always #20 i_clk = ~i_clk;

	always @(posedge i_clk)
		cycle <= cycle + 1;

	// truncated mean of the last 2**w samples with missing ones as zero
	function automatic logic signed [31:0] ref_average(input logic [3:0] w);
		longint sum;
		sum = 0;
		for (int i = 0; i < (1 << w) && i < hist.size(); i++)
			sum += hist[hist.size() - 1 - i];
		return 32'(sum >>> w);
	endfunction

	function automatic status_t exp_status();
		int n;
		n = (hist.size() < (1 << cur_wlog2)) ? hist.size() : (1 << cur_wlog2);
		return '{filled: n == (1 << cur_wlog2), fill_count: 16'(n), reserved: '0};
	endfunction

	task automatic check_avg(input avg_t got, input avg_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: o_avg got %0b/%0d, expected %0b/%0d", $time,
				got.valid, got.data, exp.valid, exp.data);
			err_count++;
		end
	endtask

	task automatic check_status(input status_t got, input status_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: STATUS got %0b/%0d, expected %0b/%0d", $time,
				got.filled, got.fill_count, exp.filled, exp.fill_count);
			err_count++;
		end
	endtask

	task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: o_apb got %h, expected %h", $time, got, exp);
			err_count++;
		end
	endtask

	// setup phase then access phase until pready
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata);
		int n;
		i_apb = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge i_clk) #2;
		i_apb.penable = 1'b1;
		n = 0;
		do begin
			@(negedge i_clk);
			rsp = o_apb;
			@(posedge i_clk) #2;
			n++;
		end while (!rsp.pready && n < 16);
		i_apb = '0;
		if (!rsp.pready) begin
			$display("error at %0t ns: APB access to 0x%02h never completed", $time, addr);
			err_count++;
		end
	endtask

	task automatic send_sample(input logic signed [31:0] data);
		i_sample = '{valid: 1'b1, data: data};
		if (cur_en) begin
			hist.push_back(data);
			last_avg = '{valid: 1'b1, data: ref_average(cur_wlog2)};
			exp_avg.push_back(last_avg);
			exp_due.push_back(cycle + 1);
		end
		@(posedge i_clk) #2;
		i_sample.valid = 1'b0;
	endtask

	task automatic send_random(input int count);
		repeat (count)
			send_sample($random(seed));
	endtask

	task automatic write_ctrl(input logic en, input logic [3:0] wlog2);
		logic bad;
		bad = wlog2 > MAX_WLOG2;
		apb_access(1'b1, addr_ctrl, {en, 27'd0, wlog2});
		check_rsp(rsp, '{pready: 1'b1, pslverr: bad, prdata: '0});
		if (!bad) begin
			if (wlog2 != cur_wlog2)
				hist.delete();
			cur_wlog2 = wlog2;
			cur_en = en;
		end
	endtask

	task automatic read_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
		apb_access(1'b0, addr, '0);
		check_rsp(rsp, '{pready: 1'b1, pslverr: err, prdata: data});
	endtask

	task automatic read_status();
		apb_access(1'b0, addr_status, '0);
		check_status(rsp.prdata, exp_status());
	endtask

	// owed results get a few cycles to show up
	task automatic wait_drain();
		int n;
		n = 0;
		do begin
			@(posedge i_clk) #2;
			n++;
		end while (exp_due.size() > 0 && n < 8);
		if (exp_due.size() > 0) begin
			$display("error at %0t ns: %0d results never appeared", $time, exp_due.size());
			err_count++;
			exp_due.delete();
			exp_avg.delete();
		end
	endtask

	task automatic end_test(input string name);
		if (err_count == test_errs) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, err_count - test_errs);
			test_fails++;
		end
		test_errs = err_count;
	endtask

	// each accepted sample owes one result on the next cycle
	always @(negedge i_clk) begin
		if (exp_due.size() > 0 && exp_due[0] == cycle) begin
			check_avg(o_avg, exp_avg.pop_front());
			void'(exp_due.pop_front());
		end else if (o_avg.valid) begin
			$display("error at %0t ns: o_avg valid without an accepted sample", $time);
			err_count++;
		end
	end

	initial begin
		seed = 74177;
		i_rst_n = 1'b0;
		i_apb = '0;
		i_sample = '0;
		cur_wlog2 = '0;
		cur_en = 1'b0;
		repeat (10) @(posedge i_clk);
		#2 i_rst_n = 1'b1;
		read_reg(addr_ctrl, '0, 1'b0);
		read_status();
		read_reg(addr_avg, '0, 1'b0);
		send_random(6);
		wait_drain();
		end_test("1 reset values, disabled input");
		write_ctrl(1'b1, 4'd0);
		send_random(10);
		wait_drain();
		end_test("2 window 1");
		write_ctrl(1'b1, 4'd3);
		send_random(7);
		read_status();
		send_random(1);
		read_status();
		send_random(32);
		wait_drain();
		read_reg(addr_avg, last_avg.data, 1'b0);
		end_test("3 window 8 random stream");
		// window change while the stream runs
		send_random(5);
		write_ctrl(1'b1, 4'd2);
		send_random(10);
		wait_drain();
		read_status();
		end_test("4 restart on window 4");
		write_ctrl(1'b0, 4'd2);
		send_random(5);
		wait_drain();
		read_status();
		write_ctrl(1'b1, 4'd2);
		send_random(6);
		wait_drain();
		end_test("5 enable off and on");
		write_ctrl(1'b1, 4'd7);
		read_reg(8'h0c, '0, 1'b1);
		apb_access(1'b1, addr_avg, 32'h1234_5678);
		check_rsp(rsp, '{pready: 1'b1, pslverr: 1'b1, prdata: '0});
		read_reg(addr_ctrl, {cur_en, 27'd0, cur_wlog2}, 1'b0);
		end_test("6 bus errors");
		$display("tests 6, failing tests %0d, errors %0d", test_fails, err_count);
		if (err_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: sma_filter_top.f
source/sma_sample_pkg.sv
source/sma_regs_pkg.sv
source/sma_apb_regs.sv
source/sma_sample_ram.sv
source/sma_accumulator.sv
source/sma_filter_top.sv
tb/tb_sma_filter_top.sv
